// File: Makefile
# Verilator build and run for the tuple merge stage.
# Override any variable on the command line, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_tuple_merger
FILELIST  ?= build.f
SIM_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= === PASS ===

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG) for the pass line"
	@echo "  clean  remove $(SIM_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST SIM_DIR LOG VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(SIM_DIR)
	./$(SIM_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Result: passed"; \
	else \
		echo "Result: failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(SIM_DIR) $(LOG)

// File: build.f
+incdir+design
design/merge_data_pkg.sv
design/merge_ctrl_pkg.sv
design/tuple_fifo.sv
design/bitonic_merger.sv
design/merge_control.sv
design/tuple_merger.sv
tb/tb_tuple_merger.sv

// File: design/bitonic_merger.sv
`timescale 1ns/1ps
`include "merge_consts.svh"

module bitonic_merger import merge_data_pkg::*; (
   input  logic                                  i_clk,
   input  logic                                  i_rst_n,
   input  logic                                  i_take,
   input  logic                                  i_prime,
   input  tuple_t                                i_tuple,
   output logic                                  o_low_valid,
   output tuple_t                                o_low,
   output logic [$clog2(`MRG_PIPE_DEPTH+1)-1:0] o_busy
);

   localparam int BUSY_W = $clog2(`MRG_PIPE_DEPTH+1);

   logic   s1_valid;
   logic   s1_prime;
   tuple_t s1_lo;
   tuple_t s1_hi;
   tuple_t top_q;
   tuple_t top_eff;
   tuple_t hi_sorted;
   tuple_t lo_sorted;
   tuple_t hc_lo;
   tuple_t hc_hi;

   function automatic tuple_t sort_pair(input tuple_t p);
      tuple_t r;
      r = p;
      if (p[0] > p[1]) begin
         r[0] = p[1];
         r[1] = p[0];
      end
      return r;
   endfunction

   assign hi_sorted = sort_pair(s1_hi);
   assign lo_sorted = sort_pair(s1_lo);

   // Level two result bypasses the top register for back-to-back takes.
   assign top_eff = s1_valid ? hi_sorted : top_q;

   // Half-cleaner on new tuple against reversed top.
   always_comb begin
      hc_lo[0] = (i_tuple[0] <= top_eff[1]) ? i_tuple[0] : top_eff[1];
      hc_hi[0] = (i_tuple[0] <= top_eff[1]) ? top_eff[1] : i_tuple[0];
      hc_lo[1] = (i_tuple[1] <= top_eff[0]) ? i_tuple[1] : top_eff[0];
      hc_hi[1] = (i_tuple[1] <= top_eff[0]) ? top_eff[0] : i_tuple[1];
   end

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         s1_valid    <= 1'b0;
         s1_prime    <= 1'b0;
         o_low_valid <= 1'b0;
      end else begin
         s1_valid    <= i_take;
         s1_prime    <= i_prime;
         o_low_valid <= s1_valid && !s1_prime;   // Prime yields no output.
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_take) begin
         s1_lo <= hc_lo;
         s1_hi <= i_prime ? i_tuple : hc_hi;
      end
      if (s1_valid) begin
         top_q <= hi_sorted;
         o_low <= lo_sorted;
      end
   end

   assign o_busy = BUSY_W'(s1_valid) + BUSY_W'(o_low_valid);

endmodule

// File: design/merge_consts.svh
`ifndef MERGE_CONSTS_SVH
`define MERGE_CONSTS_SVH

// Key and tuple geometry.
`define MRG_KEY_W 32
`define MRG_TUPLE_N 2

// Buffer depths in tuples.
`define MRG_IN_DEPTH 4
`define MRG_OUT_DEPTH 8

`define MRG_PIPE_DEPTH 2             // Register levels in the merger.

`define MRG_KEY_END {`MRG_KEY_W{1'b0}}   // Stream terminator.
`define MRG_KEY_FLUSH {`MRG_KEY_W{1'b1}} // Pushes the held top out.

`endif

// File: design/merge_control.sv
`timescale 1ns/1ps
`include "merge_consts.svh"

module merge_control import merge_data_pkg::*, merge_ctrl_pkg::*; (
   input  logic                                  i_clk,
   input  logic                                  i_rst_n,
   input  tuple_t                                i_a_head,
   input  logic                                  i_a_empty,
   input  tuple_t                                i_b_head,
   input  logic                                  i_b_empty,
   input  logic [$clog2(`MRG_PIPE_DEPTH+1)-1:0] i_merge_busy,
   input  logic [$clog2(`MRG_OUT_DEPTH+1)-1:0]  i_out_count,
   output logic                                  o_take,
   output side_t                                 o_side,
   output logic                                  o_prime,
   output logic                                  o_inject_flush,
   output logic                                  o_emit_term
);

   localparam int CNT_W = $clog2(`MRG_OUT_DEPTH+1);

   merge_state_t     state;
   merge_state_t     state_nxt;
   logic             first_q;
   logic             a_end;
   logic             b_end;
   logic             both_end;
   logic             heads_ok;
   logic             room;
   logic [CNT_W-1:0] out_free;
   logic [CNT_W-1:0] need_free;

   assign a_end     = (i_a_head[0] == `MRG_KEY_END);
   assign b_end     = (i_b_head[0] == `MRG_KEY_END);
   assign both_end  = a_end && b_end;
   assign heads_ok  = !i_a_empty && !i_b_empty;
   assign out_free  = CNT_W'(`MRG_OUT_DEPTH) - i_out_count;
   assign need_free = CNT_W'(i_merge_busy) + CNT_W'(1);
   assign room      = (out_free > need_free);   // Covers in-flight items and a spare.

   always_comb begin
      if (a_end)
         o_side = SIDE_B;
      else if (b_end)
         o_side = SIDE_A;
      else if (i_a_head[0] <= i_b_head[0])
         o_side = SIDE_A;                         // Ties go to A.
      else
         o_side = SIDE_B;
   end

   always_comb begin
      state_nxt      = state;
      o_take         = 1'b0;
      o_prime        = 1'b0;
      o_inject_flush = 1'b0;
      o_emit_term    = 1'b0;
      case (state)
         IDLE: begin
            if (heads_ok)
               state_nxt = MERGE;
         end
         MERGE: begin
            if (heads_ok && room) begin
               if (both_end && first_q) begin
                  state_nxt = TERM;              // Empty merge emits only the terminator.
               end else begin
                  o_take         = 1'b1;
                  o_prime        = first_q;
                  o_inject_flush = both_end;
                  if (both_end)
                     state_nxt = FLUSH;
               end
            end
         end
         FLUSH: begin
            if (i_merge_busy == '0)
               state_nxt = TERM;
         end
         TERM: begin
            if (out_free != '0) begin
               o_emit_term = 1'b1;
               state_nxt   = IDLE;
            end
         end
         default: state_nxt = IDLE;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         state   <= IDLE;
         first_q <= 1'b1;
      end else begin
         state <= state_nxt;
         if (state == IDLE)
            first_q <= 1'b1;
         else if (o_take)
            first_q <= 1'b0;
      end
   end

   // A terminated head must stay at its side while merging.
   a_no_end_take_a: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (state == MERGE && !i_a_empty && a_end) |=> (!i_a_empty && a_end))
      else $error("merge_control: terminated side A was taken");

   a_no_end_take_b: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (state == MERGE && !i_b_empty && b_end) |=> (!i_b_empty && b_end))
      else $error("merge_control: terminated side B was taken");

endmodule

// File: design/merge_ctrl_pkg.sv
package merge_ctrl_pkg;

   typedef enum logic [1:0] {
      IDLE,                           // Waiting for both heads.
      MERGE,
      FLUSH,                          // Merger drains after the flush tuple.
      TERM
   } merge_state_t;

   typedef enum logic {
      SIDE_A,
      SIDE_B
   } side_t;

endpackage

// File: design/merge_data_pkg.sv
`include "merge_consts.svh"

package merge_data_pkg;

   // One sort key.
   typedef logic [`MRG_KEY_W-1:0] key_t;

   // Keys of a tuple in ascending order with the lower key in element 0.
   typedef key_t [`MRG_TUPLE_N-1:0] tuple_t;

endpackage

// File: design/tuple_fifo.sv
`timescale 1ns/1ps

module tuple_fifo #(
   parameter type T_PAYLOAD = logic [7:0],
   parameter int  DEPTH     = 4
) (
   input  logic                       i_clk,
   input  logic                       i_rst_n,
   input  logic                       i_write,
   input  T_PAYLOAD                   i_data,
   input  logic                       i_read,
   output T_PAYLOAD                   o_head,
   output logic                       o_empty,
   output logic                       o_full,
   output logic [$clog2(DEPTH+1)-1:0] o_count
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH+1);

   T_PAYLOAD         mem [DEPTH];
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W-1:0] wr_ptr;
   logic             do_read;
   logic             do_write;

   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(DEPTH-1))
         return '0;
      return ptr + 1'b1;
   endfunction

   assign o_empty  = (o_count == '0);
   assign o_full   = (o_count == CNT_W'(DEPTH));
   assign o_head   = mem[rd_ptr];               // Show-ahead head.
   assign do_read  = i_read && !o_empty;
   assign do_write = i_write && (!o_full || do_read);

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         rd_ptr  <= '0;
         wr_ptr  <= '0;
         o_count <= '0;
      end else begin
         if (do_read)
            rd_ptr <= ptr_inc(rd_ptr);
         if (do_write)
            wr_ptr <= ptr_inc(wr_ptr);
         case ({do_write, do_read})
            2'b10:   o_count <= o_count + 1'b1;
            2'b01:   o_count <= o_count - 1'b1;
            default: o_count <= o_count;
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (do_write)
         mem[wr_ptr] <= i_data;
   end

   a_no_overflow: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (i_write && o_full) |-> i_read)
      else $error("tuple_fifo: write while full");

   a_no_underflow: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_read |-> !o_empty)
      else $error("tuple_fifo: read while empty");

endmodule

// File: design/tuple_merger.sv
`timescale 1ns/1ps
`include "merge_consts.svh"

module tuple_merger import merge_data_pkg::*, merge_ctrl_pkg::*; (
   input  logic   i_clk,
   input  logic   i_rst_n,
   input  tuple_t i_a_data,
   input  logic   i_a_empty,
   output logic   o_a_read,
   input  tuple_t i_b_data,
   input  logic   i_b_empty,
   output logic   o_b_read,
   input  logic   i_out_ready,
   output logic   o_out_write,
   output tuple_t o_out_data
);

   localparam tuple_t FLUSH_TUPLE = {`MRG_TUPLE_N{`MRG_KEY_FLUSH}};
   localparam tuple_t END_TUPLE   = {`MRG_TUPLE_N{`MRG_KEY_END}};

   tuple_t a_head;
   tuple_t b_head;
   tuple_t merge_in;
   tuple_t low;
   tuple_t out_in;
   logic   a_empty;
   logic   a_full;
   logic   b_empty;
   logic   b_full;
   logic   a_pop;
   logic   b_pop;
   logic   out_empty;
   logic   out_write;
   logic   take;
   logic   prime;
   logic   inject_flush;
   logic   emit_term;
   side_t  side;
   logic   low_valid;
   logic [$clog2(`MRG_PIPE_DEPTH+1)-1:0] merge_busy;
   logic [$clog2(`MRG_OUT_DEPTH+1)-1:0]  out_count;

   assign o_a_read = !i_a_empty && !a_full;
   assign o_b_read = !i_b_empty && !b_full;

   // Terminators leave both inputs together.
   assign a_pop = (take && !inject_flush && side == SIDE_A) || emit_term;
   assign b_pop = (take && !inject_flush && side == SIDE_B) || emit_term;

   assign merge_in = inject_flush ? FLUSH_TUPLE : ((side == SIDE_A) ? a_head : b_head);

   assign out_write   = low_valid || emit_term;
   assign out_in      = emit_term ? END_TUPLE : low;
   assign o_out_write = i_out_ready && !out_empty;

   tuple_fifo #(.T_PAYLOAD(tuple_t), .DEPTH(`MRG_IN_DEPTH)) u_fifo_a (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_write (o_a_read),
      .i_data  (i_a_data),
      .i_read  (a_pop),
      .o_head  (a_head),
      .o_empty (a_empty),
      .o_full  (a_full),
      .o_count ()
   );

   tuple_fifo #(.T_PAYLOAD(tuple_t), .DEPTH(`MRG_IN_DEPTH)) u_fifo_b (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_write (o_b_read),
      .i_data  (i_b_data),
      .i_read  (b_pop),
      .o_head  (b_head),
      .o_empty (b_empty),
      .o_full  (b_full),
      .o_count ()
   );

   merge_control u_control (
      .i_clk          (i_clk),
      .i_rst_n        (i_rst_n),
      .i_a_head       (a_head),
      .i_a_empty      (a_empty),
      .i_b_head       (b_head),
      .i_b_empty      (b_empty),
      .i_merge_busy   (merge_busy),
      .i_out_count    (out_count),
      .o_take         (take),
      .o_side         (side),
      .o_prime        (prime),
      .o_inject_flush (inject_flush),
      .o_emit_term    (emit_term)
   );

   bitonic_merger u_merger (
      .i_clk       (i_clk),
      .i_rst_n     (i_rst_n),
      .i_take      (take),
      .i_prime     (prime),
      .i_tuple     (merge_in),
      .o_low_valid (low_valid),
      .o_low       (low),
      .o_busy      (merge_busy)
   );

   tuple_fifo #(.T_PAYLOAD(tuple_t), .DEPTH(`MRG_OUT_DEPTH)) u_fifo_out (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_write (out_write),
      .i_data  (out_in),
      .i_read  (o_out_write),
      .o_head  (o_out_data),
      .o_empty (out_empty),
      .o_full  (),
      .o_count (out_count)
   );

   // Terminator must follow the flushed top, never collide with it.
   a_term_after_drain: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      emit_term |-> (merge_busy == '0))
      else $error("tuple_merger: terminator while merger busy");

endmodule

// File: tb/tb_tuple_merger.sv
`timescale 1ns/1ps

module tb_tuple_merger import merge_data_pkg::*; ();

   localparam int NUM_CASES    = 8;
   localparam int MAX_TUPLES   = 4;
   localparam int RESET_CYCLES = 5;
   localparam int IDLE_CYCLES  = 10;
   localparam int MAX_CYCLES   = 200 * NUM_CASES + RESET_CYCLES;

   // Stream keys with the lower key first and zero padding past the tuple count.
   localparam key_t KEYS_A [NUM_CASES][2*MAX_TUPLES] = '{
      '{1, 4, 6, 9, 12, 15, 20, 22},
      '{5, 10, 15, 20, 25, 30, 0, 0},
      '{0, 0, 0, 0, 0, 0, 0, 0},
      '{0, 0, 0, 0, 0, 0, 0, 0},
      '{5, 5, 7, 7, 9, 9, 0, 0},
      '{2, 11, 13, 17, 19, 40, 41, 41},
      '{100, 200, 0, 0, 0, 0, 0, 0},
      '{32'h0000_0003, 32'h8000_0000, 32'hffff_fffd, 32'hffff_fffe, 0, 0, 0, 0}};
   localparam key_t KEYS_B [NUM_CASES][2*MAX_TUPLES] = '{
      '{2, 3, 7, 8, 10, 11, 25, 30},
      '{1, 2, 0, 0, 0, 0, 0, 0},
      '{3, 4, 8, 9, 0, 0, 0, 0},
      '{0, 0, 0, 0, 0, 0, 0, 0},
      '{5, 7, 7, 9, 9, 9, 0, 0},
      '{1, 3, 18, 19, 40, 50, 60, 70},
      '{50, 60, 70, 150, 210, 300, 301, 302},
      '{1, 32'h7fff_ffff, 32'h8000_0000, 32'hffff_fffe, 0, 0, 0, 0}};
   localparam int NA [NUM_CASES]       = '{4, 3, 0, 0, 3, 4, 1, 2};
   localparam int NB [NUM_CASES]       = '{4, 1, 2, 0, 3, 4, 4, 2};
   localparam bit RND_SRC [NUM_CASES]  = '{0, 0, 0, 0, 0, 1, 1, 0};
   localparam bit RND_SINK [NUM_CASES] = '{0, 0, 0, 0, 0, 1, 1, 1};

   logic   i_clk;
   logic   i_rst_n;
   tuple_t i_a_data;
   logic   i_a_empty;
   logic   o_a_read;
   tuple_t i_b_data;
   logic   i_b_empty;
   logic   o_b_read;
   logic   i_out_ready;
   logic   o_out_write;
   tuple_t o_out_data;

   tuple_t src_a[$];
   tuple_t src_b[$];
   tuple_t expect_q[$];
   int     rd_a;
   int     rd_b;
   int     got;
   int     cur_case;
   bit     a_shown;
   bit     b_shown;
   bit     rnd_src;
   bit     rnd_sink;
   integer seed;
   int     errors;
   int     cycles = 0;

   tuple_merger u_dut (
      .i_clk       (i_clk),
      .i_rst_n     (i_rst_n),
      .i_a_data    (i_a_data),
      .i_a_empty   (i_a_empty),
      .o_a_read    (o_a_read),
      .i_b_data    (i_b_data),
      .i_b_empty   (i_b_empty),
      .o_b_read    (o_b_read),
      .i_out_ready (i_out_ready),
      .o_out_write (o_out_write),
      .o_out_data  (o_out_data)
   );

   initial i_clk = 1'b0;
   always #5 i_clk = ~i_clk;

   always @(posedge i_clk) begin
      cycles = cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout in case %0d, got %0d of %0d output tuples.",
                  cur_case, got, expect_q.size());
         $display("=== FAIL ===");
         $finish;
      end
   end

   function automatic tuple_t make_tuple(input key_t lo, input key_t hi);
      tuple_t t;
      t[0] = lo;
      t[1] = hi;
      return t;
   endfunction

   task automatic check_output(input tuple_t act);
      if (got >= expect_q.size()) begin
         errors++;
         $display("Unexpected extra output tuple %h at %0t.", act, $time);
      end else begin
         if (act !== expect_q[got]) begin
            errors++;
            $display("ERROR at %0t: o_out_data expected %h, got %h",
                     $time, expect_q[got], act);
         end
         got++;
      end
   endtask

   // A presented source head stays until it is read.
   task automatic drive_inputs();
      bit hold_a;
      bit hold_b;
      hold_a = rnd_src && (($random(seed) & 3) == 0);
      hold_b = rnd_src && (($random(seed) & 3) == 0);
      if (rd_a < src_a.size() && (a_shown || !hold_a)) begin
         i_a_empty = 1'b0;
         i_a_data  = src_a[rd_a];
         a_shown   = 1'b1;
      end else begin
         i_a_empty = 1'b1;
         i_a_data  = '0;
      end
      if (rd_b < src_b.size() && (b_shown || !hold_b)) begin
         i_b_empty = 1'b0;
         i_b_data  = src_b[rd_b];
         b_shown   = 1'b1;
      end else begin
         i_b_empty = 1'b1;
         i_b_data  = '0;
      end
      i_out_ready = rnd_sink ? (($random(seed) & 1) != 0) : 1'b1;
   endtask

   // Samples at the falling edge and drives 1 ns after the rising edge.
   task automatic step_cycle();
      bit rd_a_s;
      bit rd_b_s;
      @(negedge i_clk);
      rd_a_s = o_a_read;
      rd_b_s = o_b_read;
      if ((rd_a_s && i_a_empty) || (rd_b_s && i_b_empty)) begin
         errors++;
         $display("A read strobe was raised while its source was empty at %0t.", $time);
      end
      if (o_out_write && !i_out_ready) begin
         errors++;
         $display("o_out_write was raised while the sink was not ready at %0t.", $time);
      end
      if (o_out_write)
         check_output(o_out_data);
      @(posedge i_clk);
      #1;
      if (rd_a_s) begin
         rd_a++;
         a_shown = 1'b0;
      end
      if (rd_b_s) begin
         rd_b++;
         b_shown = 1'b0;
      end
      drive_inputs();
   endtask

   task automatic run_case(input int c);
      key_t   all_keys[$];
      tuple_t t;
      src_a    = {};
      src_b    = {};
      expect_q = {};
      for (int i = 0; i < NA[c]; i++) begin
         t = make_tuple(KEYS_A[c][2*i], KEYS_A[c][2*i+1]);
         src_a.push_back(t);
         all_keys.push_back(t[0]);
         all_keys.push_back(t[1]);
      end
      for (int i = 0; i < NB[c]; i++) begin
         t = make_tuple(KEYS_B[c][2*i], KEYS_B[c][2*i+1]);
         src_b.push_back(t);
         all_keys.push_back(t[0]);
         all_keys.push_back(t[1]);
      end
      src_a.push_back(make_tuple(0, 0));           // Stream terminators.
      src_b.push_back(make_tuple(0, 0));
      all_keys.sort();
      for (int i = 0; i < all_keys.size() / 2; i++)
         expect_q.push_back(make_tuple(all_keys[2*i], all_keys[2*i+1]));
      expect_q.push_back(make_tuple(0, 0));
      cur_case = c;
      rd_a     = 0;
      rd_b     = 0;
      got      = 0;
      a_shown  = 1'b0;
      b_shown  = 1'b0;
      rnd_src  = RND_SRC[c];
      rnd_sink = RND_SINK[c];
      while (got < expect_q.size())
         step_cycle();
      rnd_sink = 1'b0;
      repeat (IDLE_CYCLES) step_cycle();           // Catches extra tuples.
      if (rd_a != src_a.size() || rd_b != src_b.size()) begin
         errors++;
         $display("Case %0d did not consume both input streams (A %0d of %0d, B %0d of %0d).",
                  c, rd_a, src_a.size(), rd_b, src_b.size());
      end
   endtask

   initial begin
      seed        = 32'h752f939d;
      errors      = 0;
      cur_case    = -1;
      rd_a        = 0;
      rd_b        = 0;
      got         = 0;
      a_shown     = 1'b0;
      b_shown     = 1'b0;
      rnd_src     = 1'b0;
      rnd_sink    = 1'b0;
      i_rst_n     = 1'b0;
      i_a_data    = '0;
      i_a_empty   = 1'b1;
      i_b_data    = '0;
      i_b_empty   = 1'b1;
      i_out_ready = 1'b1;
      repeat (RESET_CYCLES) @(posedge i_clk);
      #1;
      i_rst_n = 1'b1;
      repeat (IDLE_CYCLES) step_cycle();           // DUT stays quiet with both sources empty.
      for (int c = 0; c < NUM_CASES; c++)
         run_case(c);
      $display("Finished %0d cases with %0d error(s).", NUM_CASES, errors);
      if (errors == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

endmodule
